// File: common/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define DEC_XLEN        32
`define DEC_ARCH_REG_W  5
`define DEC_PREG_W      6    // 64 physical registers

`define DEC_OPCODE_W    7
`define DEC_FUNCT3_W    3
`define DEC_FUNCT7_W    7

// lsb of each field in the instruction word
`define DEC_RD_LSB      7
`define DEC_FUNCT3_LSB  12
`define DEC_RS1_LSB     15
`define DEC_RS2_LSB     20
`define DEC_FUNCT7_LSB  25

`endif

// File: common/riscv_isa_pkg.sv
`include "decode_defs.svh"

package riscv_isa_pkg;

   // major opcodes of the rv32i subset
   typedef enum logic [`DEC_OPCODE_W-1:0]
   {
      OPC_LOAD     = 7'h03,
      OPC_MISC_MEM = 7'h0f,  // fence
      OPC_OP_IMM   = 7'h13,
      OPC_AUIPC    = 7'h17,
      OPC_STORE    = 7'h23,
      OPC_OP       = 7'h33,
      OPC_LUI      = 7'h37,
      OPC_BRANCH   = 7'h63,
      OPC_JALR     = 7'h67,
      OPC_JAL      = 7'h6f
   } opcode_e;

   typedef enum logic [`DEC_FUNCT7_W-1:0]
   {
      F7_BASE = 7'h00,
      F7_ALT  = 7'h20        // sub, sra
   } funct7_e;

endpackage

// File: common/uop_pkg.sv
package uop_pkg;

   typedef enum logic [5:0]
   {
      II,
      FETCH_PF,
      NOP,
      LB, LH, LW, LBU, LHU,
      SB, SH, SW,
      ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
      SLLI, SRLI, SRAI,
      ADDU, SUBU, SLL, SLT, SLTU,
      XOR, SRL, SRA, OR, AND,
      LUI, AUIPC,
      BEQ, BNE, BLT, BGE, BLTU, BGEU,
      J, JAL, JR, JALR, RET
   } uop_op_e;

   // which immediate goes out, pc-relative ones get pc added
   typedef enum logic [2:0]
   {
      IMM_NONE,
      IMM_I,
      IMM_S,
      IMM_U,
      IMM_PC_U,
      IMM_PC_B,
      IMM_PC_J
   } imm_fmt_e;

endpackage

// File: decode/field_extract.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module field_extract (
   input  logic [31:0]             insn,
   output logic [`DEC_PREG_W-1:0]  rd,
   output logic [`DEC_PREG_W-1:0]  rs1,
   output logic [`DEC_PREG_W-1:0]  rs2,
   output logic [`DEC_XLEN-1:0]    imm_i,
   output logic [`DEC_XLEN-1:0]    imm_s,
   output logic [`DEC_XLEN-1:0]    imm_b,
   output logic [`DEC_XLEN-1:0]    imm_u,
   output logic [`DEC_XLEN-1:0]    imm_j
);

   localparam int ZP = `DEC_PREG_W - `DEC_ARCH_REG_W;

   logic sgn;

   assign sgn = insn[31];

   // zero-extend to physical index width
   assign rd  = {{ZP{1'b0}}, insn[`DEC_RD_LSB +: `DEC_ARCH_REG_W]};
   assign rs1 = {{ZP{1'b0}}, insn[`DEC_RS1_LSB +: `DEC_ARCH_REG_W]};
   assign rs2 = {{ZP{1'b0}}, insn[`DEC_RS2_LSB +: `DEC_ARCH_REG_W]};

   assign imm_i = {{(`DEC_XLEN-12){sgn}}, insn[31:20]};
   assign imm_s = {{(`DEC_XLEN-12){sgn}}, insn[31:25], insn[11:7]};

   // b and j keep bit 0 clear
   assign imm_b = {{(`DEC_XLEN-13){sgn}}, insn[31], insn[7], insn[30:25],
                   insn[11:8], 1'b0};
   assign imm_j = {{(`DEC_XLEN-21){sgn}}, insn[31], insn[19:12], insn[20],
                   insn[30:21], 1'b0};

   assign imm_u = {insn[31:12], 12'd0};

endmodule

// File: decode/op_classify.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module op_classify (
   input  logic [31:0]          insn,
   input  logic                 page_fault,
   output uop_pkg::uop_op_e     op,
   output uop_pkg::imm_fmt_e    imm_fmt,
   output logic                 src_a_used,
   output logic                 src_b_used,
   output logic                 dst_used,
   output logic                 is_mem,
   output logic                 is_store,
   output logic                 is_br,
   output logic                 is_int,
   output logic                 is_cheap_int
);

   logic [`DEC_OPCODE_W-1:0] opcode;
   logic [`DEC_FUNCT3_W-1:0] funct3;
   logic [`DEC_FUNCT7_W-1:0] funct7;

   assign opcode = insn[`DEC_OPCODE_W-1:0];
   assign funct3 = insn[`DEC_FUNCT3_LSB +: `DEC_FUNCT3_W];
   assign funct7 = insn[`DEC_FUNCT7_LSB +: `DEC_FUNCT7_W];

   always_comb
   begin
      op = uop_pkg::II;
      imm_fmt = uop_pkg::IMM_NONE;
      src_a_used = 1'b0;
      src_b_used = 1'b0;
      dst_used = 1'b0;
      is_mem = 1'b0;
      is_store = 1'b0;
      is_br = 1'b0;
      is_int = 1'b0;
      is_cheap_int = 1'b0;
      case (opcode)
         riscv_isa_pkg::OPC_LOAD:
         begin
            {src_a_used, dst_used, is_mem} = 3'b111;
            imm_fmt = uop_pkg::IMM_I;
            case (funct3)
               3'd0: op = uop_pkg::LB;
               3'd1: op = uop_pkg::LH;
               3'd2: op = uop_pkg::LW;
               3'd4: op = uop_pkg::LBU;
               3'd5: op = uop_pkg::LHU;
               default: op = uop_pkg::II;   // ld, lwu and reserved
            endcase
         end
         riscv_isa_pkg::OPC_STORE:
         begin
            {src_a_used, src_b_used, is_mem, is_store} = 4'b1111;
            imm_fmt = uop_pkg::IMM_S;
            case (funct3)
               3'd0: op = uop_pkg::SB;
               3'd1: op = uop_pkg::SH;
               3'd2: op = uop_pkg::SW;
               default: op = uop_pkg::II;
            endcase
         end
         riscv_isa_pkg::OPC_MISC_MEM: op = uop_pkg::NOP;   // fence
         riscv_isa_pkg::OPC_OP_IMM:
         begin
            {src_a_used, dst_used, is_int, is_cheap_int} = 4'b1111;
            imm_fmt = uop_pkg::IMM_I;
            case (funct3)
               3'd0: op = uop_pkg::ADDI;
               3'd1: op = uop_pkg::SLLI;
               3'd2: op = uop_pkg::SLTI;
               3'd3: op = uop_pkg::SLTIU;
               3'd4: op = uop_pkg::XORI;
               3'd5: op = (insn[31:26] == 6'h00) ? uop_pkg::SRLI :
                          (insn[31:26] == 6'h10) ? uop_pkg::SRAI : uop_pkg::II;
               3'd6: op = uop_pkg::ORI;
               default: op = uop_pkg::ANDI;
            endcase
         end
         riscv_isa_pkg::OPC_OP:
         begin
            {src_a_used, src_b_used, dst_used, is_int, is_cheap_int} = 5'b11111;
            if (funct7 == riscv_isa_pkg::F7_BASE)
            begin
               case (funct3)
                  3'd0: op = uop_pkg::ADDU;
                  3'd1: op = uop_pkg::SLL;
                  3'd2: op = uop_pkg::SLT;
                  3'd3: op = uop_pkg::SLTU;
                  3'd4: op = uop_pkg::XOR;
                  3'd5: op = uop_pkg::SRL;
                  3'd6: op = uop_pkg::OR;
                  default: op = uop_pkg::AND;
               endcase
            end
            else if (funct7 == riscv_isa_pkg::F7_ALT && funct3 == 3'd0)
               op = uop_pkg::SUBU;
            else if (funct7 == riscv_isa_pkg::F7_ALT && funct3 == 3'd5)
               op = uop_pkg::SRA;
         end
         riscv_isa_pkg::OPC_LUI:
         begin
            {dst_used, is_int, is_cheap_int} = 3'b111;
            op = uop_pkg::LUI;
            imm_fmt = uop_pkg::IMM_U;
         end
         riscv_isa_pkg::OPC_AUIPC:
         begin
            {dst_used, is_int, is_cheap_int} = 3'b111;
            op = uop_pkg::AUIPC;
            imm_fmt = uop_pkg::IMM_PC_U;
         end
         riscv_isa_pkg::OPC_BRANCH:
         begin
            {src_a_used, src_b_used, is_int, is_br, is_cheap_int} = 5'b11111;
            imm_fmt = uop_pkg::IMM_PC_B;
            case (funct3)
               3'd0: op = uop_pkg::BEQ;
               3'd1: op = uop_pkg::BNE;
               3'd4: op = uop_pkg::BLT;
               3'd5: op = uop_pkg::BGE;
               3'd6: op = uop_pkg::BLTU;
               3'd7: op = uop_pkg::BGEU;
               default: op = uop_pkg::II;
            endcase
         end
         riscv_isa_pkg::OPC_JALR:
         begin
            {src_a_used, dst_used, is_int, is_br, is_cheap_int} = 5'b11111;
            op = uop_pkg::JALR;
            imm_fmt = uop_pkg::IMM_I;
         end
         riscv_isa_pkg::OPC_JAL:
         begin
            {dst_used, is_int, is_br, is_cheap_int} = 4'b1111;
            op = uop_pkg::JAL;
            imm_fmt = uop_pkg::IMM_PC_J;
         end
         default: op = uop_pkg::II;
      endcase

      // faults and illegal encodings carry no class or register usage
      if (page_fault || op == uop_pkg::II)
      begin
         op = page_fault ? uop_pkg::FETCH_PF : uop_pkg::II;
         imm_fmt = uop_pkg::IMM_NONE;
         {src_a_used, src_b_used, dst_used} = 3'b000;
         {is_mem, is_store, is_br, is_int, is_cheap_int} = 5'b00000;
      end
   end

endmodule

// File: decode/uop_assemble.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module uop_assemble (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    insn_valid,
   input  logic [`DEC_XLEN-1:0]    pc,
   input  logic [`DEC_PREG_W-1:0]  rd,
   input  logic [`DEC_PREG_W-1:0]  rs1,
   input  logic [`DEC_PREG_W-1:0]  rs2,
   input  logic [`DEC_XLEN-1:0]    imm_i,
   input  logic [`DEC_XLEN-1:0]    imm_s,
   input  logic [`DEC_XLEN-1:0]    imm_b,
   input  logic [`DEC_XLEN-1:0]    imm_u,
   input  logic [`DEC_XLEN-1:0]    imm_j,
   input  uop_pkg::uop_op_e        op,
   input  uop_pkg::imm_fmt_e       imm_fmt,
   input  logic                    src_a_used,
   input  logic                    src_b_used,
   input  logic                    dst_used,
   input  logic                    is_mem,
   input  logic                    is_store,
   input  logic                    is_br,
   input  logic                    is_int,
   input  logic                    is_cheap_int,
   output logic                    uop_valid,
   output uop_pkg::uop_op_e        uop_op,
   output logic [`DEC_PREG_W-1:0]  uop_src_a,
   output logic [`DEC_PREG_W-1:0]  uop_src_b,
   output logic [`DEC_PREG_W-1:0]  uop_dst,
   output logic                    uop_src_a_valid,
   output logic                    uop_src_b_valid,
   output logic                    uop_dst_valid,
   output logic [`DEC_XLEN-1:0]    uop_imm,
   output logic [`DEC_XLEN-1:0]    uop_pc,
   output logic                    uop_is_mem,
   output logic                    uop_is_store,
   output logic                    uop_is_br,
   output logic                    uop_is_int,
   output logic                    uop_is_cheap_int
);

   logic                  rd_zero;
   logic                  to_nop;
   logic                  src_a_ok;
   logic                  src_b_ok;
   logic [`DEC_XLEN-1:0]  pc_off;
   logic [`DEC_XLEN-1:0]  imm_n;
   uop_pkg::uop_op_e      op_n;

   assign rd_zero = (rd == '0);
   assign to_nop = is_int && !is_br && rd_zero;   // alu, lui, auipc into x0
   assign src_a_ok = src_a_used && !to_nop;
   assign src_b_ok = src_b_used && !to_nop;

   // one adder shared by auipc, branches and jal
   assign pc_off = (imm_fmt == uop_pkg::IMM_PC_B) ? imm_b :
                   (imm_fmt == uop_pkg::IMM_PC_J) ? imm_j : imm_u;

   always_comb
   begin
      case (imm_fmt)
         uop_pkg::IMM_I: imm_n = imm_i;
         uop_pkg::IMM_S: imm_n = imm_s;
         uop_pkg::IMM_U: imm_n = imm_u;
         uop_pkg::IMM_PC_U, uop_pkg::IMM_PC_B, uop_pkg::IMM_PC_J: imm_n = pc + pc_off;
         default: imm_n = '0;
      endcase
   end

   always_comb
   begin
      op_n = op;
      if (to_nop)
         op_n = uop_pkg::NOP;
      else if (op == uop_pkg::JAL && rd_zero)
         op_n = uop_pkg::J;
      else if (op == uop_pkg::JALR && rd_zero)
         op_n = (rs1 == 'd1 || rs1 == 'd5) ? uop_pkg::RET : uop_pkg::JR;   // ra or t0
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         uop_valid <= 1'b0;
      else
         uop_valid <= insn_valid;
   end

   always_ff @(posedge clk)
   begin
      if (insn_valid)
      begin
         uop_op <= op_n;
         uop_src_a_valid <= src_a_ok;
         uop_src_b_valid <= src_b_ok;
         uop_dst_valid <= dst_used && !rd_zero;
         uop_src_a <= src_a_ok ? rs1 : '0;
         uop_src_b <= src_b_ok ? rs2 : '0;
         uop_dst <= dst_used ? rd : '0;
         uop_imm <= imm_n;
         uop_pc <= pc;
         uop_is_mem <= is_mem;
         uop_is_store <= is_store;
         uop_is_br <= is_br;
         uop_is_int <= is_int;
         uop_is_cheap_int <= is_cheap_int;
      end
   end

endmodule

// File: decode_top.f
+incdir+common
common/uop_pkg.sv
common/riscv_isa_pkg.sv
decode/field_extract.sv
decode/op_classify.sv
decode/uop_assemble.sv
src/decode_top.sv
sim/tb_decode_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f decode_top.f --top-module tb_decode_top -o tb_decode_top \
   > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_decode_top > sim.log 2>&1 || true
grep -q "SIMULATION PASSED" sim.log && echo "decode_top simulation ok" || { cat sim.log; exit 1; }

// File: sim/tb_decode_top.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module tb_decode_top;

   localparam int NUM_INSN = 2000;
   localparam int MAX_CYCLES = 10000;

   typedef struct packed
   {
      logic                    valid;
      uop_pkg::uop_op_e        op;
      logic [`DEC_PREG_W-1:0]  src_a;
      logic [`DEC_PREG_W-1:0]  src_b;
      logic [`DEC_PREG_W-1:0]  dst;
      logic                    src_a_valid;
      logic                    src_b_valid;
      logic                    dst_valid;
      logic [`DEC_XLEN-1:0]    imm;
      logic [`DEC_XLEN-1:0]    pc;
      logic [4:0]              flags;   // mem, store, br, int, cheap_int
   } uop_exp_t;

   logic                    clk;
   logic                    rst_n;
   logic                    insn_valid;
   logic [31:0]             insn;
   logic [`DEC_XLEN-1:0]    pc;
   logic                    page_fault;
   logic                    uop_valid;
   uop_pkg::uop_op_e        uop_op;
   logic [`DEC_PREG_W-1:0]  uop_src_a;
   logic [`DEC_PREG_W-1:0]  uop_src_b;
   logic [`DEC_PREG_W-1:0]  uop_dst;
   logic                    uop_src_a_valid;
   logic                    uop_src_b_valid;
   logic                    uop_dst_valid;
   logic [`DEC_XLEN-1:0]    uop_imm;
   logic [`DEC_XLEN-1:0]    uop_pc;
   logic                    uop_is_mem;
   logic                    uop_is_store;
   logic                    uop_is_br;
   logic                    uop_is_int;
   logic                    uop_is_cheap_int;

   logic [31:0]             lcg_state;

   decode_top decode_top_inst (
      .clk              (clk),
      .rst_n            (rst_n),
      .insn_valid       (insn_valid),
      .insn             (insn),
      .pc               (pc),
      .page_fault       (page_fault),
      .uop_valid        (uop_valid),
      .uop_op           (uop_op),
      .uop_src_a        (uop_src_a),
      .uop_src_b        (uop_src_b),
      .uop_dst          (uop_dst),
      .uop_src_a_valid  (uop_src_a_valid),
      .uop_src_b_valid  (uop_src_b_valid),
      .uop_dst_valid    (uop_dst_valid),
      .uop_imm          (uop_imm),
      .uop_pc           (uop_pc),
      .uop_is_mem       (uop_is_mem),
      .uop_is_store     (uop_is_store),
      .uop_is_br        (uop_is_br),
      .uop_is_int       (uop_is_int),
      .uop_is_cheap_int (uop_is_cheap_int)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state ^ (lcg_state >> 16);   // high half folded into the short-period low bits
   endfunction

   function automatic logic [6:0] pick_opcode(input logic [3:0] sel);
      case (sel)
         4'd0: return riscv_isa_pkg::OPC_LOAD;
         4'd1: return riscv_isa_pkg::OPC_MISC_MEM;
         4'd2: return riscv_isa_pkg::OPC_OP_IMM;
         4'd3: return riscv_isa_pkg::OPC_AUIPC;
         4'd4: return riscv_isa_pkg::OPC_STORE;
         4'd5: return riscv_isa_pkg::OPC_OP;
         4'd6: return riscv_isa_pkg::OPC_LUI;
         4'd7: return riscv_isa_pkg::OPC_BRANCH;
         4'd8: return riscv_isa_pkg::OPC_JALR;
         default: return riscv_isa_pkg::OPC_JAL;
      endcase
   endfunction

   function automatic logic [31:0] make_insn();
      logic [31:0] w;
      logic [31:0] r;
      w = next_rand();
      r = next_rand();
      if (r[3:0] < 4'd14)   // otherwise a raw random word
      begin
         w[6:0] = pick_opcode(r[7:4] % 4'd10);
         if (r[9:8] == 2'd0)
            w[31:25] = 7'h00;
         else if (r[9:8] == 2'd1)
            w[31:25] = 7'h20;   // sub, sra, srai
         if (r[12:10] == 3'd0)
            w[11:7] = 5'd0;
         if (r[15:13] == 3'd0)
            w[19:15] = 5'd1;
         else if (r[15:13] == 3'd1)
            w[19:15] = 5'd5;
      end
      return w;
   endfunction

   // reference decoder, built from the rv32i encoding rules
   function automatic uop_exp_t decode_model(input logic [31:0] w,
                                             input logic [`DEC_XLEN-1:0] fpc,
                                             input logic pf);
      uop_exp_t e;
      logic [`DEC_PREG_W-1:0] rd;
      logic [`DEC_PREG_W-1:0] rs1;
      logic [`DEC_PREG_W-1:0] rs2;
      logic [31:0] imm_i;
      logic [31:0] imm_s;
      logic [31:0] imm_b;
      logic [31:0] imm_u;
      logic [31:0] imm_j;
      logic use_a;
      logic use_b;
      logic use_d;
      logic alu;
      e = '0;
      e.op = uop_pkg::II;
      e.pc = fpc;
      rd = `DEC_PREG_W'(w[11:7]);
      rs1 = `DEC_PREG_W'(w[19:15]);
      rs2 = `DEC_PREG_W'(w[24:20]);
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_u = {w[31:12], 12'h000};
      imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      use_a = 1'b0;
      use_b = 1'b0;
      use_d = 1'b0;
      alu = 1'b0;
      case (w[6:0])
         riscv_isa_pkg::OPC_LOAD:
         begin
            {use_a, use_d} = 2'b11;
            e.imm = imm_i;
            e.flags = 5'b10000;
            case (w[14:12])
               3'd0: e.op = uop_pkg::LB;
               3'd1: e.op = uop_pkg::LH;
               3'd2: e.op = uop_pkg::LW;
               3'd4: e.op = uop_pkg::LBU;
               3'd5: e.op = uop_pkg::LHU;
               default: e.op = uop_pkg::II;
            endcase
         end
         riscv_isa_pkg::OPC_STORE:
         begin
            {use_a, use_b} = 2'b11;
            e.imm = imm_s;
            e.flags = 5'b11000;
            case (w[14:12])
               3'd0: e.op = uop_pkg::SB;
               3'd1: e.op = uop_pkg::SH;
               3'd2: e.op = uop_pkg::SW;
               default: e.op = uop_pkg::II;
            endcase
         end
         riscv_isa_pkg::OPC_MISC_MEM: e.op = uop_pkg::NOP;
         riscv_isa_pkg::OPC_OP_IMM:
         begin
            {use_a, use_d, alu} = 3'b111;
            e.imm = imm_i;
            e.flags = 5'b00011;
            case (w[14:12])
               3'd0: e.op = uop_pkg::ADDI;
               3'd1: e.op = uop_pkg::SLLI;
               3'd2: e.op = uop_pkg::SLTI;
               3'd3: e.op = uop_pkg::SLTIU;
               3'd4: e.op = uop_pkg::XORI;
               3'd6: e.op = uop_pkg::ORI;
               3'd7: e.op = uop_pkg::ANDI;
               default:
               begin
                  if (w[31:26] == 6'h00)
                     e.op = uop_pkg::SRLI;
                  else if (w[31:26] == 6'h10)
                     e.op = uop_pkg::SRAI;
               end
            endcase
         end
         riscv_isa_pkg::OPC_OP:
         begin
            {use_a, use_b, use_d, alu} = 4'b1111;
            e.flags = 5'b00011;
            if (w[31:25] == 7'h00)
            begin
               case (w[14:12])
                  3'd0: e.op = uop_pkg::ADDU;
                  3'd1: e.op = uop_pkg::SLL;
                  3'd2: e.op = uop_pkg::SLT;
                  3'd3: e.op = uop_pkg::SLTU;
                  3'd4: e.op = uop_pkg::XOR;
                  3'd5: e.op = uop_pkg::SRL;
                  3'd6: e.op = uop_pkg::OR;
                  default: e.op = uop_pkg::AND;
               endcase
            end
            else if (w[31:25] == 7'h20 && w[14:12] == 3'd0)
               e.op = uop_pkg::SUBU;
            else if (w[31:25] == 7'h20 && w[14:12] == 3'd5)
               e.op = uop_pkg::SRA;
         end
         riscv_isa_pkg::OPC_LUI:
         begin
            {use_d, alu} = 2'b11;
            e.op = uop_pkg::LUI;
            e.imm = imm_u;
            e.flags = 5'b00011;
         end
         riscv_isa_pkg::OPC_AUIPC:
         begin
            {use_d, alu} = 2'b11;
            e.op = uop_pkg::AUIPC;
            e.imm = fpc + imm_u;
            e.flags = 5'b00011;
         end
         riscv_isa_pkg::OPC_BRANCH:
         begin
            {use_a, use_b} = 2'b11;
            e.imm = fpc + imm_b;
            e.flags = 5'b00111;
            case (w[14:12])
               3'd0: e.op = uop_pkg::BEQ;
               3'd1: e.op = uop_pkg::BNE;
               3'd4: e.op = uop_pkg::BLT;
               3'd5: e.op = uop_pkg::BGE;
               3'd6: e.op = uop_pkg::BLTU;
               3'd7: e.op = uop_pkg::BGEU;
               default: e.op = uop_pkg::II;
            endcase
         end
         riscv_isa_pkg::OPC_JALR:
         begin
            {use_a, use_d} = 2'b11;
            e.op = uop_pkg::JALR;
            e.imm = imm_i;
            e.flags = 5'b00111;
         end
         riscv_isa_pkg::OPC_JAL:
         begin
            use_d = 1'b1;
            e.op = uop_pkg::JAL;
            e.imm = fpc + imm_j;
            e.flags = 5'b00111;
         end
         default: e.op = uop_pkg::II;
      endcase
      if (pf || e.op == uop_pkg::II)
      begin
         e.op = pf ? uop_pkg::FETCH_PF : uop_pkg::II;
         e.imm = '0;
         e.flags = 5'b00000;
         {use_a, use_b, use_d, alu} = 4'b0000;
      end
      if (alu && rd == '0)   // result into x0, class flags stay
      begin
         e.op = uop_pkg::NOP;
         {use_a, use_b} = 2'b00;
      end
      else if (e.op == uop_pkg::JAL && rd == '0)
         e.op = uop_pkg::J;
      else if (e.op == uop_pkg::JALR && rd == '0)
         e.op = (rs1 == 6'd1 || rs1 == 6'd5) ? uop_pkg::RET : uop_pkg::JR;
      e.src_a_valid = use_a;
      e.src_b_valid = use_b;
      e.dst_valid = use_d && rd != '0;
      e.src_a = use_a ? rs1 : '0;
      e.src_b = use_b ? rs2 : '0;
      e.dst = use_d ? rd : '0;
      return e;
   endfunction

   task automatic abort_run();
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic check_valid(input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Error: %0t ns: uop_valid is %b, expected %b", $time, got, exp);
         abort_run();
      end
   endtask

   task automatic check_op(input uop_pkg::uop_op_e got, input uop_pkg::uop_op_e exp);
      if (got !== exp)
      begin
         $display("Error: %0t ns: uop_op is %s (%0d), expected %s", $time, got.name(), got,
                  exp.name());
         abort_run();
      end
   endtask

   task automatic check_reg(input string what, input logic [`DEC_PREG_W-1:0] got_idx,
                            input logic [`DEC_PREG_W-1:0] exp_idx, input logic got_v,
                            input logic exp_v);
      if (got_idx !== exp_idx || got_v !== exp_v)
      begin
         $display("Error: %0t ns: %s is %0d valid %b, expected %0d valid %b", $time, what,
                  got_idx, got_v, exp_idx, exp_v);
         abort_run();
      end
   endtask

   task automatic check_word(input string what, input logic [`DEC_XLEN-1:0] got,
                             input logic [`DEC_XLEN-1:0] exp);
      if (got !== exp)
      begin
         $display("Error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_flags(input logic [4:0] got, input logic [4:0] exp);
      if (got !== exp)
      begin
         $display("Error: %0t ns: class flags mem/store/br/int/cheap are %b, expected %b",
                  $time, got, exp);
         abort_run();
      end
   endtask

   task automatic compare_outputs(input uop_exp_t e);
      check_valid(uop_valid, e.valid);
      if (e.valid)
      begin
         check_op(uop_op, e.op);
         check_reg("src_a", uop_src_a, e.src_a, uop_src_a_valid, e.src_a_valid);
         check_reg("src_b", uop_src_b, e.src_b, uop_src_b_valid, e.src_b_valid);
         check_reg("dst", uop_dst, e.dst, uop_dst_valid, e.dst_valid);
         check_word("uop_imm", uop_imm, e.imm);
         check_word("uop_pc", uop_pc, e.pc);
         check_flags({uop_is_mem, uop_is_store, uop_is_br, uop_is_int, uop_is_cheap_int},
                     e.flags);
      end
   endtask

   initial
   begin
      uop_exp_t exp_q;
      uop_exp_t exp_next;
      logic [31:0] r;
      logic [31:0] w;
      logic [31:0] p;
      logic v;
      logic pf;
      int sent;
      int checked;
      int cycles;
      int wait_cnt;
      lcg_state = 32'hf8b8;
      rst_n = 1'b0;
      insn_valid = 1'b0;
      insn = '0;
      pc = '0;
      page_fault = 1'b0;
      exp_q = '0;
      sent = 0;
      checked = 0;
      cycles = 0;
      wait_cnt = 0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      while (uop_valid !== 1'b0 && wait_cnt < 8)
      begin
         @(negedge clk);
         wait_cnt++;
      end
      if (uop_valid !== 1'b0)
      begin
         $display("uop_valid did not go low after reset");
         abort_run();
      end
      while (checked < NUM_INSN && cycles < MAX_CYCLES)
      begin
         @(posedge clk);
         v = 1'b0;
         pf = 1'b0;
         w = '0;
         p = '0;
         if (sent < NUM_INSN)
         begin
            r = next_rand();
            v = (r[1:0] != 2'b00);
            pf = (r[6:2] == 5'd0);   // roughly one in 32
            w = make_insn();
            p = next_rand();
            if (v)
               sent++;
         end
         insn_valid <= v;
         insn <= w;
         pc <= p;
         page_fault <= pf;
         exp_next = decode_model(w, p, pf);
         exp_next.valid = v;
         @(negedge clk);
         compare_outputs(exp_q);
         if (exp_q.valid)
            checked++;
         exp_q = exp_next;
         cycles++;
      end
      if (checked == NUM_INSN)
      begin
         $display("SIMULATION PASSED");
         $finish;
      end
      else
      begin
         $display("run timed out after %0d cycles with %0d micro-ops checked", cycles,
                  checked);
         abort_run();
      end
   end

endmodule

// File: src/decode_top.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module decode_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    insn_valid,
   input  logic [31:0]             insn,
   input  logic [`DEC_XLEN-1:0]    pc,
   input  logic                    page_fault,
   output logic                    uop_valid,
   output uop_pkg::uop_op_e        uop_op,
   output logic [`DEC_PREG_W-1:0]  uop_src_a,
   output logic [`DEC_PREG_W-1:0]  uop_src_b,
   output logic [`DEC_PREG_W-1:0]  uop_dst,
   output logic                    uop_src_a_valid,
   output logic                    uop_src_b_valid,
   output logic                    uop_dst_valid,
   output logic [`DEC_XLEN-1:0]    uop_imm,
   output logic [`DEC_XLEN-1:0]    uop_pc,
   output logic                    uop_is_mem,
   output logic                    uop_is_store,
   output logic                    uop_is_br,
   output logic                    uop_is_int,
   output logic                    uop_is_cheap_int
);

   logic [`DEC_PREG_W-1:0]  rd;
   logic [`DEC_PREG_W-1:0]  rs1;
   logic [`DEC_PREG_W-1:0]  rs2;
   logic [`DEC_XLEN-1:0]    imm_i;
   logic [`DEC_XLEN-1:0]    imm_s;
   logic [`DEC_XLEN-1:0]    imm_b;
   logic [`DEC_XLEN-1:0]    imm_u;
   logic [`DEC_XLEN-1:0]    imm_j;
   uop_pkg::uop_op_e        op;
   uop_pkg::imm_fmt_e       imm_fmt;
   logic                    src_a_used;
   logic                    src_b_used;
   logic                    dst_used;
   logic                    is_mem;
   logic                    is_store;
   logic                    is_br;
   logic                    is_int;
   logic                    is_cheap_int;

   field_extract field_extract_inst (
      .insn  (insn),
      .rd    (rd),
      .rs1   (rs1),
      .rs2   (rs2),
      .imm_i (imm_i),
      .imm_s (imm_s),
      .imm_b (imm_b),
      .imm_u (imm_u),
      .imm_j (imm_j)
   );

   op_classify op_classify_inst (
      .insn         (insn),
      .page_fault   (page_fault),
      .op           (op),
      .imm_fmt      (imm_fmt),
      .src_a_used   (src_a_used),
      .src_b_used   (src_b_used),
      .dst_used     (dst_used),
      .is_mem       (is_mem),
      .is_store     (is_store),
      .is_br        (is_br),
      .is_int       (is_int),
      .is_cheap_int (is_cheap_int)
   );

   uop_assemble uop_assemble_inst (
      .clk              (clk),
      .rst_n            (rst_n),
      .insn_valid       (insn_valid),
      .pc               (pc),
      .rd               (rd),
      .rs1              (rs1),
      .rs2              (rs2),
      .imm_i            (imm_i),
      .imm_s            (imm_s),
      .imm_b            (imm_b),
      .imm_u            (imm_u),
      .imm_j            (imm_j),
      .op               (op),
      .imm_fmt          (imm_fmt),
      .src_a_used       (src_a_used),
      .src_b_used       (src_b_used),
      .dst_used         (dst_used),
      .is_mem           (is_mem),
      .is_store         (is_store),
      .is_br            (is_br),
      .is_int           (is_int),
      .is_cheap_int     (is_cheap_int),
      .uop_valid        (uop_valid),
      .uop_op           (uop_op),
      .uop_src_a        (uop_src_a),
      .uop_src_b        (uop_src_b),
      .uop_dst          (uop_dst),
      .uop_src_a_valid  (uop_src_a_valid),
      .uop_src_b_valid  (uop_src_b_valid),
      .uop_dst_valid    (uop_dst_valid),
      .uop_imm          (uop_imm),
      .uop_pc           (uop_pc),
      .uop_is_mem       (uop_is_mem),
      .uop_is_store     (uop_is_store),
      .uop_is_br        (uop_is_br),
      .uop_is_int       (uop_is_int),
      .uop_is_cheap_int (uop_is_cheap_int)
   );

endmodule
